//--- hdl/ram_cfg.svh
`ifndef RAM_CFG_SVH
`define RAM_CFG_SVH

// Array geometry
`define RAM_DEPTH 512
`define RAM_ADDR_W 9
`define RAM_BYTE_W 8
`define RAM_BUS_W 64

// Configuration registers at the bottom of the array
`define RAM_RESERVED_COUNT 1
`define RAM_RESERVED_DEFAULT 8'hA5

// Reset value of ordinary bytes
`define RAM_DATA_DEFAULT 0

`endif

//--- hdl/ram_pkg.sv
`default_nettype none

`include "ram_cfg.svh"

package ram_pkg;

    // Encoding 3 is not a legal size
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } access_size_t;

    typedef struct packed {
        logic [`RAM_ADDR_W-1:0] addr;
        access_size_t           size;
    } rd_req_t;

    typedef struct packed {
        logic [`RAM_ADDR_W-1:0] addr;
        access_size_t           size;
        logic [`RAM_BUS_W-1:0]  data;
    } wr_req_t;

    // Number of byte lanes moved by one access
    function automatic logic [3:0] lane_count(access_size_t size);
        case (size)
            size_byte:  return 4'd1;
            size_word:  return 4'd4;
            size_dword: return 4'd8;
            default:    return 4'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hdl/request_capture.sv
`default_nettype none

module request_capture #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ins,
    input  payload_t payload,
    output payload_t req,
    output logic     apply,
    output logic     idle
);

    logic ins_q;
    logic accept;

    // Rising edge of the instruction level taken only when free
    assign accept = ins && !ins_q && idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ins_q <= 1'b0;
        end else begin
            ins_q <= ins;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req <= '0;
        end else if (accept) begin
            req <= payload;
        end
    end

    // One busy cycle per accepted request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            apply <= 1'b0;
            idle  <= 1'b1;
        end else begin
            apply <= accept;
            idle  <= !accept;
        end
    end

    // An edge seen while free is latched and applied in the next cycle
    a_edge_applied: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ins) && idle |=> apply && !idle && req == $past(payload)
    );

endmodule

`default_nettype wire

//--- hdl/byte_store.sv
`default_nettype none

`include "ram_cfg.svh"

module byte_store
    import ram_pkg::*;
(
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  wr_req_t                                        wr_req,
    input  logic                                           wr_apply,
    output logic [`RAM_DEPTH-1:0][`RAM_BYTE_W-1:0]          mem_bytes,
    output logic [`RAM_RESERVED_COUNT-1:0][`RAM_BYTE_W-1:0] reserved_regs
);

    localparam int LANES  = `RAM_BUS_W / `RAM_BYTE_W;
    localparam int LANE_W = $clog2(LANES);

    logic [3:0] lanes;

    assign lanes = lane_count(wr_req.size);

    for (genvar i = 0; i < `RAM_DEPTH; i++) begin : g_byte
        localparam logic [`RAM_BYTE_W-1:0] RESET_VALUE =
            (i < `RAM_RESERVED_COUNT) ? `RAM_RESERVED_DEFAULT
                                      : `RAM_BYTE_W'(`RAM_DATA_DEFAULT);

        logic [`RAM_ADDR_W:0]   offset;
        logic                   hit;
        logic [`RAM_BYTE_W-1:0] value_q;

        // Distance from the request address, top bit set when below it
        assign offset = (`RAM_ADDR_W+1)'(i) - {1'b0, wr_req.addr};

        // Lanes past the last address have no byte and simply vanish
        assign hit = wr_apply && !offset[`RAM_ADDR_W] && (offset < {6'd0, lanes});

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                value_q <= RESET_VALUE;
            end else if (hit) begin
                value_q <= wr_req.data[offset[LANE_W-1:0]*`RAM_BYTE_W +: `RAM_BYTE_W];
            end
        end

        assign mem_bytes[i] = value_q;
    end

    // Configuration bytes sit at the bottom addresses
    assign reserved_regs = mem_bytes[`RAM_RESERVED_COUNT-1:0];

    // The write capture must never release an illegal size
    a_legal_wr_size: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_apply |-> wr_req.size inside {size_byte, size_word, size_dword}
    );

endmodule

`default_nettype wire

//--- hdl/read_assemble.sv
`default_nettype none

`include "ram_cfg.svh"

module read_assemble
    import ram_pkg::*;
(
    input  logic                                  clk,
    input  rd_req_t                               rd_req,
    input  logic [`RAM_DEPTH-1:0][`RAM_BYTE_W-1:0] mem_bytes,
    output logic [`RAM_BUS_W-1:0]                 rd_data
);

    localparam int LANES = `RAM_BUS_W / `RAM_BYTE_W;

    logic [3:0] lanes;

    assign lanes = lane_count(rd_req.size);

    // Little endian, lane 0 carries the byte at the request address
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic [`RAM_ADDR_W:0] byte_addr;
        logic                 in_use;

        assign byte_addr = {1'b0, rd_req.addr} + (`RAM_ADDR_W+1)'(l);

        // Lanes beyond the size or past the top read as zero
        assign in_use = (l < lanes) && (byte_addr < `RAM_DEPTH);

        assign rd_data[l*`RAM_BYTE_W +: `RAM_BYTE_W] =
            in_use ? mem_bytes[byte_addr[`RAM_ADDR_W-1:0]] : '0;
    end

    // Latched read size comes from the capture and must stay legal
    a_legal_rd_size: assert property (
        @(posedge clk)
        rd_req.size inside {size_byte, size_word, size_dword}
    );

endmodule

`default_nettype wire

//--- hdl/ram_top.sv
`default_nettype none

`include "ram_cfg.svh"

module ram_top
    import ram_pkg::*;
(
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           rd_ins,
    input  logic [`RAM_ADDR_W-1:0]                         rd_addr,
    input  logic [1:0]                                     rd_size,
    input  logic                                           wr_ins,
    input  logic [`RAM_ADDR_W-1:0]                         wr_addr,
    input  logic [1:0]                                     wr_size,
    input  logic [`RAM_BUS_W-1:0]                          wr_data,
    output logic [`RAM_BUS_W-1:0]                          rd_data,
    output logic                                           rd_idle,
    output logic                                           wr_idle,
    output logic [`RAM_RESERVED_COUNT-1:0][`RAM_BYTE_W-1:0] reserved_regs
);

    rd_req_t rd_payload;
    rd_req_t rd_req;
    wr_req_t wr_payload;
    wr_req_t wr_req;
    logic    wr_apply;

    logic [`RAM_DEPTH-1:0][`RAM_BYTE_W-1:0] mem_bytes;

    assign rd_payload = '{addr: rd_addr, size: access_size_t'(rd_size)};
    assign wr_payload = '{addr: wr_addr, size: access_size_t'(wr_size), data: wr_data};

    // Read side needs no apply pulse, data is combinational
    request_capture #(.payload_t(rd_req_t)) i_rd_capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .ins     (rd_ins),
        .payload (rd_payload),
        .req     (rd_req),
        .apply   (),
        .idle    (rd_idle)
    );

    request_capture #(.payload_t(wr_req_t)) i_wr_capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .ins     (wr_ins),
        .payload (wr_payload),
        .req     (wr_req),
        .apply   (wr_apply),
        .idle    (wr_idle)
    );

    byte_store i_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_req        (wr_req),
        .wr_apply      (wr_apply),
        .mem_bytes     (mem_bytes),
        .reserved_regs (reserved_regs)
    );

    read_assemble i_read (
        .clk       (clk),
        .rd_req    (rd_req),
        .mem_bytes (mem_bytes),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

//--- bench/tb_ram.sv
`default_nettype none

`include "ram_cfg.svh"

module tb_ram;

    localparam int PERIOD     = 100;
    localparam int ITERATIONS = 400;
    localparam int BURST_LEN  = 200;
    localparam int TIMEOUT    = 20;
    localparam int RES_W      = `RAM_RESERVED_COUNT * `RAM_BYTE_W;

    localparam logic [1:0] SIZE_BYTE  = 2'd0;
    localparam logic [1:0] SIZE_WORD  = 2'd1;
    localparam logic [1:0] SIZE_DWORD = 2'd2;

    logic                                           clk;
    logic                                           rst_n;
    logic                                           rd_ins;
    logic [`RAM_ADDR_W-1:0]                         rd_addr;
    logic [1:0]                                     rd_size;
    logic                                           wr_ins;
    logic [`RAM_ADDR_W-1:0]                         wr_addr;
    logic [1:0]                                     wr_size;
    logic [`RAM_BUS_W-1:0]                          wr_data;
    logic [`RAM_BUS_W-1:0]                          rd_data;
    logic                                           rd_idle;
    logic                                           wr_idle;
    logic [`RAM_RESERVED_COUNT-1:0][`RAM_BYTE_W-1:0] reserved_regs;

    // Reference copy of the array
    logic [7:0] model [0:`RAM_DEPTH-1];
    integer     seed;
    int         error_count;

    // Write port state for the cycle by cycle checks
    logic prev_wr_ins;
    logic model_wr_idle;

    ram_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_ins        (rd_ins),
        .rd_addr       (rd_addr),
        .rd_size       (rd_size),
        .wr_ins        (wr_ins),
        .wr_addr       (wr_addr),
        .wr_size       (wr_size),
        .wr_data       (wr_data),
        .rd_data       (rd_data),
        .rd_idle       (rd_idle),
        .wr_idle       (wr_idle),
        .reserved_regs (reserved_regs)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [1:0] rand_size();
        logic [31:0] r;
        r = rand_word();
        return r[1:0] % 2'd3;
    endfunction

    function automatic int lanes_of(input logic [1:0] size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_WORD: return 4;
            default:   return 8;
        endcase
    endfunction

    function automatic void model_write(input logic [`RAM_ADDR_W-1:0] addr,
                                        input logic [1:0] size, input logic [63:0] data);
        logic [`RAM_ADDR_W:0] a;
        logic [63:0]          shifted;
        for (int l = 0; l < lanes_of(size); l++) begin
            a = {1'b0, addr} + (`RAM_ADDR_W+1)'(l);
            shifted = data >> (8 * l);
            // Lanes past the top are lost
            if (a < (`RAM_ADDR_W+1)'(`RAM_DEPTH)) begin
                model[a[`RAM_ADDR_W-1:0]] = shifted[7:0];
            end
        end
    endfunction

    function automatic logic [63:0] model_read(input logic [`RAM_ADDR_W-1:0] addr,
                                               input logic [1:0] size);
        logic [`RAM_ADDR_W:0] a;
        logic [63:0]          result;
        result = '0;
        for (int l = 0; l < lanes_of(size); l++) begin
            a = {1'b0, addr} + (`RAM_ADDR_W+1)'(l);
            if (a < (`RAM_ADDR_W+1)'(`RAM_DEPTH)) begin
                result = result | (64'(model[a[`RAM_ADDR_W-1:0]]) << (8 * l));
            end
        end
        return result;
    endfunction

    function automatic logic [RES_W-1:0] model_reserved();
        logic [RES_W-1:0] v;
        v = '0;
        for (int r = 0; r < `RAM_RESERVED_COUNT; r++) begin
            v = v | (RES_W'(model[`RAM_ADDR_W'(r)]) << (8 * r));
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at time %0t: %s expected 0x%h, got 0x%h",
                     $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Idle must drop for exactly one cycle after the request edge
    task automatic wait_idle(input logic is_write);
        int    cycles;
        logic  idle_now;
        string port;
        cycles = 0;
        idle_now = 1'b0;
        if (is_write) begin
            port = "wr_idle";
        end else begin
            port = "rd_idle";
        end
        while (!idle_now && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            idle_now = is_write ? wr_idle : rd_idle;
        end
        if (!idle_now) begin
            $display("%s did not return high within %0d cycles of the request", port, TIMEOUT);
            $display(">>> FAIL");
            $fatal(1, "Port stuck busy");
        end else begin
            check({port, " busy cycles"}, 64'd1, 64'(cycles - 1));
        end
    endtask

    task automatic do_write(input logic [`RAM_ADDR_W-1:0] addr, input logic [1:0] size,
                            input logic [63:0] data);
        @(negedge clk);
        wr_addr = addr;
        wr_size = size;
        wr_data = data;
        wr_ins = 1'b1;
        model_write(addr, size, data);
        wait_idle(1'b1);
        wr_ins = 1'b0;
        check("reserved_regs", 64'(model_reserved()), 64'(reserved_regs));
    endtask

    task automatic do_read(input logic [`RAM_ADDR_W-1:0] addr, input logic [1:0] size);
        @(negedge clk);
        rd_addr = addr;
        rd_size = size;
        rd_ins = 1'b1;
        wait_idle(1'b0);
        rd_ins = 1'b0;
        check($sformatf("rd_data at 0x%h", addr), model_read(addr, size), rd_data);
    endtask

    task automatic start_write_tracking();
        wr_ins = 1'b0;
        @(negedge clk);
        prev_wr_ins = 1'b0;
        model_wr_idle = 1'b1;
        check("wr_idle", 64'd1, 64'(wr_idle));
    endtask

    // The levels seen at the last rising edge are still on the ports
    task automatic track_write_cycle();
        logic accept;
        @(negedge clk);
        accept = wr_ins && !prev_wr_ins && model_wr_idle;
        prev_wr_ins = wr_ins;
        model_wr_idle = !accept;
        if (accept) begin
            model_write(wr_addr, wr_size, wr_data);
        end
        check("wr_idle", 64'(model_wr_idle), 64'(wr_idle));
    endtask

    task automatic hold_write_test(input logic [`RAM_ADDR_W-1:0] addr);
        start_write_tracking();
        wr_addr = addr;
        wr_size = SIZE_DWORD;
        wr_data = {rand_word(), rand_word()};
        wr_ins = 1'b1;
        track_write_cycle();
        // New data while the level stays high must not be written
        repeat (6) begin
            wr_data = {rand_word(), rand_word()};
            track_write_cycle();
        end
        wr_ins = 1'b0;
        track_write_cycle();
        do_read(addr, SIZE_DWORD);
    endtask

    task automatic toggle_burst();
        logic [31:0] r;
        start_write_tracking();
        repeat (BURST_LEN) begin
            r = rand_word();
            wr_ins = r[0];
            wr_addr = r[`RAM_ADDR_W:1];
            wr_size = r[31:30] % 2'd3;
            wr_data = {rand_word(), rand_word()};
            track_write_cycle();
        end
        wr_ins = 1'b0;
        track_write_cycle();
    endtask

    initial begin
        logic [31:0]            r;
        logic [`RAM_ADDR_W-1:0] addr;
        seed = 32'h7345;
        error_count = 0;
        rst_n = 1'b0;
        rd_ins = 1'b0;
        rd_addr = '0;
        rd_size = SIZE_BYTE;
        wr_ins = 1'b0;
        wr_addr = '0;
        wr_size = SIZE_BYTE;
        wr_data = '0;
        prev_wr_ins = 1'b0;
        model_wr_idle = 1'b1;
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            model[`RAM_ADDR_W'(i)] = (i < `RAM_RESERVED_COUNT) ? `RAM_RESERVED_DEFAULT
                                                               : 8'(`RAM_DATA_DEFAULT);
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // Reset state
        check("rd_idle", 64'd1, 64'(rd_idle));
        check("wr_idle", 64'd1, 64'(wr_idle));
        check("reserved_regs", 64'(model_reserved()), 64'(reserved_regs));
        do_read('0, SIZE_DWORD);

        // Configuration registers
        for (int i = 0; i < `RAM_RESERVED_COUNT; i++) begin
            r = rand_word();
            do_write(`RAM_ADDR_W'(i), SIZE_BYTE, 64'(r[7:0]));
            do_read(`RAM_ADDR_W'(i), SIZE_BYTE);
        end

        // Accesses running off the top of the array
        for (int a = `RAM_DEPTH - 8; a < `RAM_DEPTH; a++) begin
            addr = `RAM_ADDR_W'(a);
            do_write(addr, (a % 2 == 0) ? SIZE_DWORD : SIZE_WORD, {rand_word(), rand_word()});
            do_read(addr, SIZE_DWORD);
            do_read(addr, SIZE_WORD);
        end

        repeat (ITERATIONS) begin
            r = rand_word();
            addr = r[`RAM_ADDR_W-1:0];
            if (r[31]) begin
                do_write(addr, rand_size(), {rand_word(), rand_word()});
            end else begin
                do_read(addr, rand_size());
            end
        end

        r = rand_word();
        hold_write_test(r[`RAM_ADDR_W-1:0]);
        toggle_burst();

        // Whole array against the model
        for (int a = 0; a < `RAM_DEPTH; a += 8) begin
            do_read(`RAM_ADDR_W'(a), SIZE_DWORD);
        end

        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/ram_pkg.sv
hdl/request_capture.sv
hdl/byte_store.sv
hdl/read_assemble.sv
hdl/ram_top.sv
bench/tb_ram.sv

//--- run.sh
#!/usr/bin/env bash
# Build the RAM testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_ram -f sim.f -Mdir obj_dir \
    && ./obj_dir/Vtb_ram | tee /dev/stderr | grep -F ">>> PASS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
